/* hdl/dataMem.sv */
`timescale 1ns/1ns
`default_nettype none

module dataMem #(
	parameter int dataDepth = 64
) (
	input wire logic clk,
	input wire logic wrEn,
	input wire rvIsaPkg::wordT addr,
	input wire rvIsaPkg::wordT wrData,
	output rvIsaPkg::wordT rdData
);

	rvIsaPkg::wordT mem [dataDepth];
	logic [31:0] wordIdx;

	// byte address to word index, wrapping at the depth
	assign wordIdx = (addr >> 2) % dataDepth;

	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wordIdx] <= wrData;
		end
	end

	assign rdData = mem[wordIdx];

endmodule

`default_nettype wire

/* hdl/execUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module execUnit (
	input wire rvIsaPkg::wordT rd1,
	input wire rvIsaPkg::wordT rd2,
	input wire pipeCtrlPkg::fwdSelE fwdA,
	input wire pipeCtrlPkg::fwdSelE fwdB,
	input wire rvIsaPkg::wordT memResult,
	input wire rvIsaPkg::wordT wbResult,
	input wire rvIsaPkg::wordT pc,
	input wire rvIsaPkg::wordT imm,
	input wire logic aluSrcImm,
	input wire logic aluSrcZero,
	input wire rvIsaPkg::aluOpE aluOp,
	input wire pipeCtrlPkg::branchE branch,
	output rvIsaPkg::wordT aluResult,
	output rvIsaPkg::wordT storeData,
	output rvIsaPkg::wordT branchTarget,
	output logic taken
);

	rvIsaPkg::wordT srcA;
	rvIsaPkg::wordT aluA;
	rvIsaPkg::wordT aluB;
	logic [4:0] shamt;

	function automatic rvIsaPkg::wordT fwdMux(input pipeCtrlPkg::fwdSelE sel,
		input rvIsaPkg::wordT regVal, input rvIsaPkg::wordT memVal,
		input rvIsaPkg::wordT wbVal);
		rvIsaPkg::wordT val;
		case (sel)
			pipeCtrlPkg::fwdMem: val = memVal;
			pipeCtrlPkg::fwdWb:  val = wbVal;
			default:             val = regVal;
		endcase
		return val;
	endfunction

	// forwarded rs2 doubles as store data
	assign srcA = fwdMux(fwdA, rd1, memResult, wbResult);
	assign storeData = fwdMux(fwdB, rd2, memResult, wbResult);

	assign aluA = aluSrcZero ? '0 : srcA;
	assign aluB = aluSrcImm ? imm : storeData;
	assign shamt = aluB[4:0];

	always_comb begin
		case (aluOp)
			rvIsaPkg::aluAdd:  aluResult = aluA + aluB;
			rvIsaPkg::aluSub:  aluResult = aluA - aluB;
			rvIsaPkg::aluAnd:  aluResult = aluA & aluB;
			rvIsaPkg::aluOr:   aluResult = aluA | aluB;
			rvIsaPkg::aluXor:  aluResult = aluA ^ aluB;
			rvIsaPkg::aluSll:  aluResult = aluA << shamt;
			rvIsaPkg::aluSrl:  aluResult = aluA >> shamt;
			rvIsaPkg::aluSra:  aluResult = $signed(aluA) >>> shamt;
			rvIsaPkg::aluSlt:  aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
			rvIsaPkg::aluSltu: aluResult = {31'b0, aluA < aluB};
			default:           aluResult = '0;
		endcase
	end

	// compare on the forwarded register values
	always_comb begin
		case (branch)
			pipeCtrlPkg::brEq: taken = (srcA == storeData);
			pipeCtrlPkg::brNe: taken = (srcA != storeData);
			pipeCtrlPkg::brLt: taken = ($signed(srcA) < $signed(storeData));
			pipeCtrlPkg::brGe: taken = ($signed(srcA) >= $signed(storeData));
			default:           taken = 1'b0;
		endcase
	end

	assign branchTarget = pc + imm;

endmodule

`default_nettype wire

/* hdl/hazardUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
	input wire rvIsaPkg::regIdxT rs1D,
	input wire rvIsaPkg::regIdxT rs2D,
	input wire rvIsaPkg::regIdxT rs1E,
	input wire rvIsaPkg::regIdxT rs2E,
	input wire rvIsaPkg::regIdxT rdE,
	input wire rvIsaPkg::regIdxT rdM,
	input wire rvIsaPkg::regIdxT rdW,
	input wire logic loadE,
	input wire logic regWriteM,
	input wire logic regWriteW,
	input wire logic takenE,
	output pipeCtrlPkg::fwdSelE fwdA,
	output pipeCtrlPkg::fwdSelE fwdB,
	output logic stall,
	output logic flushD,
	output logic flushE
);

	// memory stage is younger, so it wins over writeback
	function automatic pipeCtrlPkg::fwdSelE fwdFor(input rvIsaPkg::regIdxT src);
		pipeCtrlPkg::fwdSelE sel;
		if (src != '0 && regWriteM && src == rdM) begin
			sel = pipeCtrlPkg::fwdMem;
		end else if (src != '0 && regWriteW && src == rdW) begin
			sel = pipeCtrlPkg::fwdWb;
		end else begin
			sel = pipeCtrlPkg::fwdNone;
		end
		return sel;
	endfunction

	assign fwdA = fwdFor(rs1E);
	assign fwdB = fwdFor(rs2E);

	// load data is not ready until writeback
	assign stall = loadE && (rdE != '0) && (rs1D == rdE || rs2D == rdE);
	assign flushD = takenE;
	assign flushE = stall || takenE;

endmodule

`default_nettype wire

/* hdl/instrDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
	input wire rvIsaPkg::wordT instr,
	output logic regWrite,
	output logic memWrite,
	output pipeCtrlPkg::resultSelE resultSel,
	output logic aluSrcImm,
	output logic aluSrcZero,
	output rvIsaPkg::aluOpE aluOp,
	output pipeCtrlPkg::branchE branch,
	output rvIsaPkg::wordT imm
);

	rvIsaPkg::opcodeE opcode;
	logic [2:0] funct3;
	logic isShift;
	pipeCtrlPkg::immSelE immSel;

	assign opcode = rvIsaPkg::opcodeE'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign isShift = (funct3 == rvIsaPkg::f3Sll) || (funct3 == rvIsaPkg::f3Srl);

	// alt is bit 30 where it selects SUB or SRA
	function automatic rvIsaPkg::aluOpE aluFromFunct3(input logic [2:0] f3, input logic alt);
		rvIsaPkg::aluOpE op;
		case (f3)
			rvIsaPkg::f3AddSub: op = alt ? rvIsaPkg::aluSub : rvIsaPkg::aluAdd;
			rvIsaPkg::f3Sll:    op = rvIsaPkg::aluSll;
			rvIsaPkg::f3Slt:    op = rvIsaPkg::aluSlt;
			rvIsaPkg::f3Sltu:   op = rvIsaPkg::aluSltu;
			rvIsaPkg::f3Xor:    op = rvIsaPkg::aluXor;
			rvIsaPkg::f3Srl:    op = alt ? rvIsaPkg::aluSra : rvIsaPkg::aluSrl;
			rvIsaPkg::f3Or:     op = rvIsaPkg::aluOr;
			default:            op = rvIsaPkg::aluAnd;
		endcase
		return op;
	endfunction

	always_comb begin
		regWrite = 1'b0;
		memWrite = 1'b0;
		resultSel = pipeCtrlPkg::resultAlu;
		aluSrcImm = 1'b0;
		aluSrcZero = 1'b0;
		aluOp = rvIsaPkg::aluAdd;
		branch = pipeCtrlPkg::brNone;
		immSel = pipeCtrlPkg::immI;
		case (opcode)
			rvIsaPkg::opLoad: begin
				regWrite = 1'b1;
				resultSel = pipeCtrlPkg::resultMem;
				aluSrcImm = 1'b1;
			end
			rvIsaPkg::opStore: begin
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
				immSel = pipeCtrlPkg::immS;
			end
			rvIsaPkg::opRtype: begin
				regWrite = 1'b1;
				aluOp = aluFromFunct3(funct3, instr[30]);
			end
			rvIsaPkg::opItype: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				// addi ignores bit 30, only srai uses it
				aluOp = aluFromFunct3(funct3, instr[30] && funct3 == rvIsaPkg::f3Srl);
				if (isShift) begin
					immSel = pipeCtrlPkg::immShift;
				end
			end
			rvIsaPkg::opBranch: begin
				immSel = pipeCtrlPkg::immB;
				case (funct3)
					rvIsaPkg::f3Beq: branch = pipeCtrlPkg::brEq;
					rvIsaPkg::f3Bne: branch = pipeCtrlPkg::brNe;
					rvIsaPkg::f3Blt: branch = pipeCtrlPkg::brLt;
					rvIsaPkg::f3Bge: branch = pipeCtrlPkg::brGe;
					default:         branch = pipeCtrlPkg::brNone;
				endcase
			end
			rvIsaPkg::opLui: begin
				// upper immediate added to a zero A operand
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				aluSrcZero = 1'b1;
				immSel = pipeCtrlPkg::immU;
			end
			// bubble, keeps the defaults
			rvIsaPkg::opNull: ;
			default: ;
		endcase
	end

	always_comb begin
		case (immSel)
			pipeCtrlPkg::immI:     imm = {{20{instr[31]}}, instr[31:20]};
			pipeCtrlPkg::immShift: imm = {27'b0, instr[24:20]};
			pipeCtrlPkg::immS:     imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			pipeCtrlPkg::immB:     imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
			pipeCtrlPkg::immU:     imm = {instr[31:12], 12'b0};
			default:               imm = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/pipeCtrlPkg.sv */
`default_nettype none

package pipeCtrlPkg;

	// immediate formats built in decode
	typedef enum logic [2:0] {
		immI,
		immShift,
		immS,
		immB,
		immU
	} immSelE;

	typedef enum logic [2:0] {
		brNone,
		brEq,
		brNe,
		brLt,
		brGe
	} branchE;

	// operand source in execute
	typedef enum logic [1:0] {
		fwdNone,
		fwdWb,
		fwdMem
	} fwdSelE;

	typedef enum logic {
		resultAlu,
		resultMem
	} resultSelE;

endpackage

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input wire logic clk,
	input wire logic rst,
	input wire rvIsaPkg::regIdxT rs1,
	input wire rvIsaPkg::regIdxT rs2,
	input wire rvIsaPkg::regIdxT rd,
	input wire logic wrEn,
	input wire rvIsaPkg::wordT wrData,
	output rvIsaPkg::wordT rd1,
	output rvIsaPkg::wordT rd2
);

	rvIsaPkg::wordT regs [32];
	logic doWrite;

	// x0 is never written
	assign doWrite = wrEn && (rd != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (doWrite) begin
			regs[rd] <= wrData;
		end
	end

	// same-cycle write is bypassed to the read ports
	assign rd1 = (rs1 == '0) ? '0 : (doWrite && rd == rs1) ? wrData : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : (doWrite && rd == rs2) ? wrData : regs[rs2];

endmodule

`default_nettype wire

/* hdl/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regIdxT;

	// major opcodes kept by this core
	typedef enum logic [6:0] {
		opNull   = 7'b0000000,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opRtype  = 7'b0110011,
		opItype  = 7'b0010011,
		opBranch = 7'b1100011,
		opLui    = 7'b0110111
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSll,
		aluSrl,
		aluSra,
		aluSlt,
		aluSltu
	} aluOpE;

	// alu funct3 codes, shared by R-type and I-type
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3Srl    = 3'b101;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	// branch funct3 codes
	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;
	localparam logic [2:0] f3Blt = 3'b100;
	localparam logic [2:0] f3Bge = 3'b101;

endpackage

`default_nettype wire

/* hdl/rvPipeCore.sv */
`timescale 1ns/1ns
`default_nettype none

module rvPipeCore #(
	parameter int dataDepth = 64
) (
	input wire logic clk,
	input wire logic rst,
	input wire rvIsaPkg::wordT instr,
	output rvIsaPkg::wordT instrAddr,
	output logic storeValid,
	output rvIsaPkg::wordT storeAddr,
	output rvIsaPkg::wordT storeData
);

	// fetch
	rvIsaPkg::wordT pc;
	rvIsaPkg::wordT pcNext;

	// decode
	rvIsaPkg::wordT instrD;
	rvIsaPkg::wordT pcD;
	rvIsaPkg::regIdxT rs1D;
	rvIsaPkg::regIdxT rs2D;
	rvIsaPkg::regIdxT rdD;
	logic regWriteD;
	logic memWriteD;
	pipeCtrlPkg::resultSelE wbSelD;
	logic aluSrcImmD;
	logic aluSrcZeroD;
	rvIsaPkg::aluOpE aluCtrlD;
	pipeCtrlPkg::branchE brTypeD;
	rvIsaPkg::wordT immD;
	rvIsaPkg::wordT rd1D;
	rvIsaPkg::wordT rd2D;

	// execute
	logic regWriteE;
	logic memWriteE;
	pipeCtrlPkg::resultSelE wbSelE;
	logic aluSrcImmE;
	logic aluSrcZeroE;
	rvIsaPkg::aluOpE aluCtrlE;
	pipeCtrlPkg::branchE brTypeE;
	rvIsaPkg::wordT immE;
	rvIsaPkg::wordT rd1E;
	rvIsaPkg::wordT rd2E;
	rvIsaPkg::wordT pcE;
	rvIsaPkg::regIdxT rs1E;
	rvIsaPkg::regIdxT rs2E;
	rvIsaPkg::regIdxT rdE;
	rvIsaPkg::wordT aluResultE;
	rvIsaPkg::wordT storeDataE;
	rvIsaPkg::wordT branchTargetE;
	logic takenE;
	logic loadE;

	// memory
	logic regWriteM;
	logic memWriteM;
	pipeCtrlPkg::resultSelE wbSelM;
	rvIsaPkg::regIdxT rdM;
	rvIsaPkg::wordT aluResultM;
	rvIsaPkg::wordT storeDataM;
	rvIsaPkg::wordT readDataM;

	// writeback
	logic regWriteW;
	pipeCtrlPkg::resultSelE wbSelW;
	rvIsaPkg::regIdxT rdW;
	rvIsaPkg::wordT aluResultW;
	rvIsaPkg::wordT readDataW;
	rvIsaPkg::wordT resultW;

	// hazard controls
	pipeCtrlPkg::fwdSelE fwdA;
	pipeCtrlPkg::fwdSelE fwdB;
	logic stall;
	logic flushD;
	logic flushE;

	assign pcNext = takenE ? branchTargetE : pc + 32'd4;
	assign instrAddr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= pcNext;
		end
	end

	// all-zero instruction is the bubble
	always_ff @(posedge clk) begin
		if (rst || flushD) begin
			instrD <= '0;
		end else if (!stall) begin
			instrD <= instr;
			pcD <= pc;
		end
	end

	assign rs1D = instrD[19:15];
	assign rs2D = instrD[24:20];
	assign rdD = instrD[11:7];

	instrDecoder decoder_i (
		.instr(instrD),
		.regWrite(regWriteD),
		.memWrite(memWriteD),
		.resultSel(wbSelD),
		.aluSrcImm(aluSrcImmD),
		.aluSrcZero(aluSrcZeroD),
		.aluOp(aluCtrlD),
		.branch(brTypeD),
		.imm(immD)
	);

	regFile regFile_i (
		.clk(clk),
		.rst(rst),
		.rs1(rs1D),
		.rs2(rs2D),
		.rd(rdW),
		.wrEn(regWriteW),
		.wrData(resultW),
		.rd1(rd1D),
		.rd2(rd2D)
	);

	// decode/execute control, cleared to a bubble on flush
	always_ff @(posedge clk) begin
		if (rst || flushE) begin
			regWriteE <= 1'b0;
			memWriteE <= 1'b0;
			wbSelE <= pipeCtrlPkg::resultAlu;
			brTypeE <= pipeCtrlPkg::brNone;
			rs1E <= '0;
			rs2E <= '0;
			rdE <= '0;
		end else begin
			regWriteE <= regWriteD;
			memWriteE <= memWriteD;
			wbSelE <= wbSelD;
			brTypeE <= brTypeD;
			rs1E <= rs1D;
			rs2E <= rs2D;
			rdE <= rdD;
		end
	end

	always_ff @(posedge clk) begin
		aluSrcImmE <= aluSrcImmD;
		aluSrcZeroE <= aluSrcZeroD;
		aluCtrlE <= aluCtrlD;
		immE <= immD;
		rd1E <= rd1D;
		rd2E <= rd2D;
		pcE <= pcD;
	end

	assign loadE = (wbSelE == pipeCtrlPkg::resultMem);

	execUnit exec_i (
		.rd1(rd1E),
		.rd2(rd2E),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.memResult(aluResultM),
		.wbResult(resultW),
		.pc(pcE),
		.imm(immE),
		.aluSrcImm(aluSrcImmE),
		.aluSrcZero(aluSrcZeroE),
		.aluOp(aluCtrlE),
		.branch(brTypeE),
		.aluResult(aluResultE),
		.storeData(storeDataE),
		.branchTarget(branchTargetE),
		.taken(takenE)
	);

	hazardUnit hazard_i (
		.rs1D(rs1D),
		.rs2D(rs2D),
		.rs1E(rs1E),
		.rs2E(rs2E),
		.rdE(rdE),
		.rdM(rdM),
		.rdW(rdW),
		.loadE(loadE),
		.regWriteM(regWriteM),
		.regWriteW(regWriteW),
		.takenE(takenE),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.stall(stall),
		.flushD(flushD),
		.flushE(flushE)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteM <= 1'b0;
			memWriteM <= 1'b0;
			wbSelM <= pipeCtrlPkg::resultAlu;
			rdM <= '0;
		end else begin
			regWriteM <= regWriteE;
			memWriteM <= memWriteE;
			wbSelM <= wbSelE;
			rdM <= rdE;
		end
	end

	always_ff @(posedge clk) begin
		aluResultM <= aluResultE;
		storeDataM <= storeDataE;
	end

	// store port mirrors the data memory write
	assign storeValid = memWriteM;
	assign storeAddr = aluResultM;
	assign storeData = storeDataM;

	dataMem #(
		.dataDepth(dataDepth)
	) dataMem_i (
		.clk(clk),
		.wrEn(memWriteM),
		.addr(aluResultM),
		.wrData(storeDataM),
		.rdData(readDataM)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteW <= 1'b0;
			wbSelW <= pipeCtrlPkg::resultAlu;
			rdW <= '0;
		end else begin
			regWriteW <= regWriteM;
			wbSelW <= wbSelM;
			rdW <= rdM;
		end
	end

	always_ff @(posedge clk) begin
		aluResultW <= aluResultM;
		readDataW <= readDataM;
	end

	assign resultW = (wbSelW == pipeCtrlPkg::resultMem) ? readDataW : aluResultW;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it, and greps the log for the pass line
verilator --binary --timing -j 0 --top-module rvPipeCoreTb -f rvPipeCore.f -o simv \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1; cat sim.log
grep -q '^\*\*\* PASSED \*\*\*$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* rvPipeCore.f */
hdl/rvIsaPkg.sv
hdl/pipeCtrlPkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/hazardUnit.sv
hdl/dataMem.sv
hdl/rvPipeCore.sv
verif/rvPipeCoreTb.sv

/* verif/rvPipeCoreTb.sv */
`timescale 1ns/1ns
`default_nettype none

module rvPipeCoreTb;

	localparam int clkPeriod = 100;
	localparam int runCycles = 200;
	localparam int numTests = 5;
	localparam int testBudget = 250;
	localparam logic [6:0] opItype = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;

	logic clk;
	logic rst;
	rvIsaPkg::wordT instr;
	rvIsaPkg::wordT instrAddr;
	logic storeValid;
	rvIsaPkg::wordT storeAddr;
	rvIsaPkg::wordT storeData;

	// program image with zero words acting as bubbles
	rvIsaPkg::wordT imem [256];
	int progLen;
	int storeOff;
	rvIsaPkg::wordT expAddr[$];
	rvIsaPkg::wordT expData[$];

	rvPipeCore #(
		.dataDepth(64)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrAddr(instrAddr),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

	assign instr = (instrAddr[31:10] == '0) ? imem[instrAddr[9:2]] : '0;

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(numTests * testBudget * clkPeriod);
		$display("timeout: the tests did not finish within %0d cycles", numTests * testBudget);
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

	// instruction encodings
	function automatic rvIsaPkg::wordT rTypeWord(input logic alt, input logic [2:0] f3,
		input rvIsaPkg::regIdxT rd, input rvIsaPkg::regIdxT rs1, input rvIsaPkg::regIdxT rs2);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic rvIsaPkg::wordT iTypeWord(input logic [11:0] imm, input logic [2:0] f3,
		input rvIsaPkg::regIdxT rd, input rvIsaPkg::regIdxT rs1, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic rvIsaPkg::wordT storeWord(input logic [11:0] imm,
		input rvIsaPkg::regIdxT rs2, input rvIsaPkg::regIdxT rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic rvIsaPkg::wordT branchWord(input logic [12:0] off, input logic [2:0] f3,
		input rvIsaPkg::regIdxT rs1, input rvIsaPkg::regIdxT rs2);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic rvIsaPkg::wordT luiWord(input logic [19:0] upper,
		input rvIsaPkg::regIdxT rd);
		return {upper, rd, 7'b0110111};
	endfunction

	function automatic rvIsaPkg::wordT signExtend12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// {bit 30, funct3} for operation k in aluModel order
	function automatic logic [3:0] aluFields(input int k);
		case (k)
			0: return 4'b0000;
			1: return 4'b1000;
			2: return 4'b0111;
			3: return 4'b0110;
			4: return 4'b0100;
			5: return 4'b0001;
			6: return 4'b0101;
			7: return 4'b1101;
			8: return 4'b0010;
			default: return 4'b0011;
		endcase
	endfunction

	// RV32I semantics of add sub and or xor sll srl sra slt sltu
	function automatic rvIsaPkg::wordT aluModel(input int k, input rvIsaPkg::wordT a,
		input rvIsaPkg::wordT b);
		case (k)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return a << b[4:0];
			6: return a >> b[4:0];
			7: return (a >> b[4:0]) | (a[31] ? ~(32'hFFFFFFFF >> b[4:0]) : 32'h0);
			8: return {31'b0, $signed(a) < $signed(b)};
			default: return {31'b0, a < b};
		endcase
	endfunction

	function automatic logic branchModel(input logic [2:0] f3, input rvIsaPkg::wordT a,
		input rvIsaPkg::wordT b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			default: return 1'b0;
		endcase
	endfunction

	task automatic compareAddr(input string testName, input rvIsaPkg::wordT expected,
		input rvIsaPkg::wordT actual);
		if (expected !== actual) begin
			$display("** Error %s store address: expected %h, actual %h", testName, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "store address mismatch");
		end
	endtask

	task automatic compareData(input string testName, input rvIsaPkg::wordT expected,
		input rvIsaPkg::wordT actual);
		if (expected !== actual) begin
			$display("** Error %s store data: expected %h, actual %h", testName, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "store data mismatch");
		end
	endtask

	task automatic putInstr(input rvIsaPkg::wordT w);
		imem[8'(progLen)] = w;
		progLen++;
	endtask

	// hidden stores sit in a branch shadow and are not expected
	task automatic storeRegister(input rvIsaPkg::regIdxT rs, input rvIsaPkg::wordT value,
		input logic visible);
		putInstr(storeWord(12'(storeOff), rs, 5'd0));
		if (visible) begin
			expAddr.push_back(32'(storeOff));
			expData.push_back(value);
		end
		storeOff += 4;
	endtask

	// reset stays high while the next program is written
	task automatic resetAndClear();
		@(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		imem = '{default: '0};
		progLen = 0;
		storeOff = 0;
		expAddr.delete();
		expData.delete();
	endtask

	task automatic runProgram(input string testName);
		rvIsaPkg::wordT gotAddr[$];
		rvIsaPkg::wordT gotData[$];
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		repeat (runCycles) begin
			@(negedge clk);
			if (storeValid) begin
				gotAddr.push_back(storeAddr);
				gotData.push_back(storeData);
			end
		end
		if (gotData.size() != expData.size()) begin
			$display("%s: expected %0d stores but the core made %0d", testName,
				expData.size(), gotData.size());
			$display("*** FAILED ***");
			$fatal(1, "store count mismatch");
		end
		for (int i = 0; i < expData.size(); i++) begin
			compareAddr(testName, expAddr[i], gotAddr[i]);
			compareData(testName, expData[i], gotData[i]);
		end
		$display("%s: %0d stores compared", testName, expData.size());
	endtask

	task automatic aluTest();
		logic [11:0] immA;
		logic [11:0] immB;
		logic [11:0] immC;
		logic [3:0] f;
		logic [4:0] shamt;
		logic isShift;
		rvIsaPkg::wordT a;
		rvIsaPkg::wordT b;
		rvIsaPkg::wordT c;
		rvIsaPkg::wordT sum;
		resetAndClear();
		immA = 12'($urandom());
		immB = 12'($urandom());
		a = signExtend12(immA);
		b = signExtend12(immB);
		putInstr(iTypeWord(immA, 3'b000, 5'd1, 5'd0, opItype));
		putInstr(iTypeWord(immB, 3'b000, 5'd2, 5'd0, opItype));
		// each result is stored straight away so store data comes from the memory stage
		for (int k = 0; k < 10; k++) begin
			f = aluFields(k);
			putInstr(rTypeWord(f[3], f[2:0], 5'd3, 5'd1, 5'd2));
			storeRegister(5'd3, aluModel(k, a, b), 1'b1);
		end
		for (int k = 0; k < 10; k++) begin
			f = aluFields(k);
			isShift = (k >= 5) && (k <= 7);
			shamt = 5'($urandom());
			immC = isShift ? {1'b0, f[3], 5'b0, shamt} : 12'($urandom());
			c = isShift ? {27'b0, shamt} : signExtend12(immC);
			// no subtract-immediate in RV32I
			if (k != 1) begin
				putInstr(iTypeWord(immC, f[2:0], 5'd4, 5'd1, opItype));
				storeRegister(5'd4, aluModel(k, a, c), 1'b1);
			end
		end
		// chain that needs both forwarding paths
		sum = a + b;
		putInstr(rTypeWord(1'b0, 3'b000, 5'd5, 5'd1, 5'd2));
		putInstr(rTypeWord(1'b1, 3'b000, 5'd6, 5'd5, 5'd1));
		putInstr(rTypeWord(1'b0, 3'b100, 5'd7, 5'd5, 5'd6));
		storeRegister(5'd7, sum ^ (sum - a), 1'b1);
		storeRegister(5'd5, sum, 1'b1);
		runProgram("alu");
	endtask

	task automatic luiSignTest();
		logic [19:0] upper;
		logic [11:0] neg;
		logic [11:0] src;
		logic [4:0] shamt;
		rvIsaPkg::wordT v;
		resetAndClear();
		upper = 20'($urandom());
		neg = {1'b1, 11'($urandom())};
		src = {1'b1, 11'($urandom())};
		shamt = 5'($urandom_range(1, 31));
		v = signExtend12(src);
		putInstr(luiWord(upper, 5'd1));
		putInstr(iTypeWord(neg, 3'b000, 5'd1, 5'd1, opItype));
		storeRegister(5'd1, {upper, 12'b0} + signExtend12(neg), 1'b1);
		putInstr(luiWord(20'h80000, 5'd2));
		storeRegister(5'd2, 32'h80000000, 1'b1);
		putInstr(iTypeWord(src, 3'b000, 5'd3, 5'd0, opItype));
		putInstr(iTypeWord({7'b0100000, shamt}, 3'b101, 5'd4, 5'd3, opItype));
		putInstr(iTypeWord({7'b0000000, shamt}, 3'b101, 5'd5, 5'd3, opItype));
		// v is negative so the arithmetic shift fills ones from the top
		storeRegister(5'd4, (v >> shamt) | ~(32'hFFFFFFFF >> shamt), 1'b1);
		storeRegister(5'd5, v >> shamt, 1'b1);
		runProgram("luiSign");
	endtask

	task automatic loadUseTest();
		logic [11:0] immA;
		logic [11:0] immB;
		rvIsaPkg::wordT a;
		rvIsaPkg::wordT b;
		resetAndClear();
		immA = 12'($urandom());
		immB = 12'($urandom());
		a = signExtend12(immA);
		b = signExtend12(immB);
		putInstr(iTypeWord(immA, 3'b000, 5'd1, 5'd0, opItype));
		putInstr(iTypeWord(immB, 3'b000, 5'd2, 5'd0, opItype));
		// scratch word at the top of data memory
		putInstr(storeWord(12'd252, 5'd1, 5'd0));
		expAddr.push_back(32'd252);
		expData.push_back(a);
		putInstr(iTypeWord(12'd252, 3'b010, 5'd3, 5'd0, opLoad));
		putInstr(rTypeWord(1'b0, 3'b000, 5'd4, 5'd3, 5'd2));
		storeRegister(5'd4, a + b, 1'b1);
		putInstr(iTypeWord(12'd252, 3'b010, 5'd5, 5'd0, opLoad));
		storeRegister(5'd5, a, 1'b1);
		putInstr(iTypeWord(12'd252, 3'b010, 5'd6, 5'd0, opLoad));
		putInstr(rTypeWord(1'b1, 3'b000, 5'd7, 5'd2, 5'd6));
		storeRegister(5'd7, b - a, 1'b1);
		runProgram("loadUse");
	endtask

	// branch over one store and then a store that always runs
	task automatic branchCase(input logic [2:0] f3, input rvIsaPkg::regIdxT rs1,
		input rvIsaPkg::regIdxT rs2, input rvIsaPkg::wordT a, input rvIsaPkg::wordT b);
		logic tk;
		tk = branchModel(f3, a, b);
		putInstr(branchWord(13'd8, f3, rs1, rs2));
		storeRegister(5'd6, 32'h111, !tk);
		storeRegister(5'd7, 32'h222, 1'b1);
	endtask

	task automatic branchTest();
		rvIsaPkg::wordT neg;
		rvIsaPkg::wordT pos;
		resetAndClear();
		neg = signExtend12(12'hFFB);
		pos = 32'd7;
		putInstr(iTypeWord(12'hFFB, 3'b000, 5'd1, 5'd0, opItype));
		putInstr(iTypeWord(12'd7, 3'b000, 5'd2, 5'd0, opItype));
		putInstr(iTypeWord(12'h111, 3'b000, 5'd6, 5'd0, opItype));
		putInstr(iTypeWord(12'h222, 3'b000, 5'd7, 5'd0, opItype));
		putInstr(iTypeWord(12'd7, 3'b000, 5'd5, 5'd0, opItype));
		branchCase(3'b000, 5'd2, 5'd5, pos, pos);
		branchCase(3'b000, 5'd1, 5'd2, neg, pos);
		branchCase(3'b001, 5'd1, 5'd2, neg, pos);
		branchCase(3'b001, 5'd2, 5'd5, pos, pos);
		// an unsigned compare would get these wrong
		branchCase(3'b100, 5'd1, 5'd2, neg, pos);
		branchCase(3'b100, 5'd2, 5'd1, pos, neg);
		branchCase(3'b101, 5'd2, 5'd1, pos, neg);
		branchCase(3'b101, 5'd1, 5'd2, neg, pos);
		branchCase(3'b101, 5'd2, 5'd5, pos, pos);
		runProgram("branch");
	endtask

	task automatic zeroRegTest();
		logic [11:0] immA;
		resetAndClear();
		immA = 12'($urandom());
		putInstr(iTypeWord(immA, 3'b000, 5'd1, 5'd0, opItype));
		putInstr(iTypeWord(12'd123, 3'b000, 5'd0, 5'd0, opItype));
		storeRegister(5'd0, 32'h0, 1'b1);
		putInstr(rTypeWord(1'b0, 3'b000, 5'd0, 5'd1, 5'd1));
		putInstr(32'h0);
		storeRegister(5'd0, 32'h0, 1'b1);
		putInstr(rTypeWord(1'b0, 3'b000, 5'd2, 5'd0, 5'd1));
		storeRegister(5'd2, signExtend12(immA), 1'b1);
		runProgram("zeroReg");
	endtask

	initial begin
		rst = 1'b1;
		imem = '{default: '0};
		void'($urandom(39));
		aluTest();
		luiSignTest();
		loadUseTest();
		branchTest();
		zeroRegTest();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
